/* all.f */
src/keypad_pkg.sv
src/key_edit_if.sv
src/keypad_scanner.sv
src/tap_tracker.sv
src/text_decoder.sv
src/keypad_text_top.sv
tests/keypad_model.sv
tests/keypad_text_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ns -j 0
TOP      := keypad_text_tb
FILELIST := all.f
BUILD    := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)
	@out="$$(./$(BUILD)/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(BUILD)

/* tests/keypad_text_tb.sv */
`timescale 1ns/1ns

module keypad_text_tb import keypad_pkg::*; ();

  localparam int CLK_PERIOD = 8;
  localparam int ROUND      = 4 * SCAN_DIV;                // clocks per scan round
  localparam int SETTLE     = 2 * ROUND;
  localparam int SHORT_HOLD = 10;                          // below one round, never debounced
  localparam int LONG_HOLD  = (DEBOUNCE_CNT + 3) * ROUND;  // always reaches an event

  logic                 clk;
  logic                 nrst;
  key_code_t            key;
  logic [3:0]           rows;
  logic [3:0]           cols;
  logic [LINE_BITS-1:0] text;

  // stimulus table, one entry per step
  logic [7:0]           step_key[$];
  int                   step_reps[$];   // presses of the same key before the check
  int                   step_hold[$];   // clocks per press
  logic [7:0]           step_low[$];
  logic [LINE_BITS-1:0] step_text[$];
  int                   limit_cycles = 0;

  keypad_model u_keypad (
    .cols (cols),
    .key  (key),
    .rows (rows)
  );

  keypad_text_top dut (
    .clk  (clk),
    .nrst (nrst),
    .rows (rows),
    .cols (cols),
    .text (text)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_value(input string name, input logic [LINE_BITS-1:0] got,
                             input logic [LINE_BITS-1:0] exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      $display("TEST FAIL");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  function automatic void add_step(input logic [7:0] k, input int reps, input bit short_press,
                                   input logic [7:0] low, input logic [LINE_BITS-1:0] txt);
    step_key.push_back(k);
    step_reps.push_back(reps);
    step_hold.push_back(short_press ? SHORT_HOLD : LONG_HOLD + int'($urandom_range(0, 31)));
    step_low.push_back(low);
    step_text.push_back(txt);
  endfunction

  function automatic void build_table();
    add_step(KEY_1, 1, 1'b0, "1", LINE_BITS'("1"));  // number mode
    add_step(KEY_C, 1, 1'b0, CH_SPACE, LINE_BITS'("1 "));
    add_step(KEY_2, 1, 1'b0, "2", LINE_BITS'("12"));
    add_step(KEY_C, 1, 1'b0, CH_SPACE, LINE_BITS'("12 "));
    add_step(KEY_3, 1, 1'b0, "3", LINE_BITS'("123"));
    add_step(KEY_4, 1, 1'b0, "4", LINE_BITS'("124"));
    add_step(KEY_5, 1, 1'b0, "5", LINE_BITS'("125"));
    add_step(KEY_6, 1, 1'b0, "6", LINE_BITS'("126"));
    add_step(KEY_7, 1, 1'b0, "7", LINE_BITS'("127"));
    add_step(KEY_8, 1, 1'b0, "8", LINE_BITS'("128"));
    add_step(KEY_9, 1, 1'b0, "9", LINE_BITS'("129"));
    add_step(KEY_0, 1, 1'b0, "0", LINE_BITS'("120"));
    add_step(KEY_STAR, 1, 1'b0, "*", LINE_BITS'("12*"));
    add_step(KEY_HASH, 1, 1'b0, "#", LINE_BITS'("12#"));
    add_step(KEY_C, 1, 1'b0, CH_SPACE, LINE_BITS'("12# "));
    add_step(KEY_5, 1, 1'b1, CH_SPACE, LINE_BITS'("12# "));  // bounce only
    add_step(KEY_D, 1, 1'b0, 8'h00, '0);
    add_step(KEY_B, 1, 1'b0, 8'h00, '0);                     // letter mode
    add_step(KEY_2, 1, 1'b0, "a", LINE_BITS'("a"));
    add_step(KEY_2, 1, 1'b0, "b", LINE_BITS'("b"));
    add_step(KEY_2, 1, 1'b0, "c", LINE_BITS'("c"));
    add_step(KEY_2, 1, 1'b0, "c", LINE_BITS'("c"));          // fourth tap holds
    add_step(KEY_C, 1, 1'b0, CH_SPACE, LINE_BITS'("c "));
    add_step(KEY_9, 3, 1'b0, "y", LINE_BITS'("cy"));
    add_step(KEY_9, 1, 1'b0, "z", LINE_BITS'("cz"));
    add_step(KEY_HASH, 1, 1'b0, 8'h00, LINE_BITS'({"c", 8'h00}));  // upper on
    add_step(KEY_5, 1, 1'b0, "J", LINE_BITS'("cJ"));
    add_step(KEY_C, 1, 1'b0, CH_SPACE, LINE_BITS'("cJ "));
    add_step(KEY_5, 1, 1'b0, "J", LINE_BITS'("cJJ"));
    add_step(KEY_5, 1, 1'b0, "K", LINE_BITS'("cJK"));
    add_step(KEY_C, 1, 1'b0, CH_SPACE, LINE_BITS'("cJK "));
    add_step(KEY_1, 1, 1'b0, "@", LINE_BITS'("cJK@"));
    add_step(KEY_1, 1, 1'b0, "_", LINE_BITS'("cJK_"));
    add_step(KEY_A, 1, 1'b0, "K", {" ", 96'h0, "cJK"});
    add_step(KEY_A, 1, 1'b0, "J", {"  ", 96'h0, "cJ"});
    add_step(KEY_C, 15, 1'b0, CH_SPACE, {"J", {15{CH_SPACE}}});
    add_step(KEY_C, 2, 1'b0, CH_SPACE, {16{CH_SPACE}});      // 17 confirms in all
    add_step(KEY_3, 1, 1'b0, "D", {{15{CH_SPACE}}, "D"});
    add_step(KEY_D, 1, 1'b0, "D", {{15{CH_SPACE}}, "D"});    // not after C, kept
    add_step(KEY_C, 1, 1'b0, CH_SPACE, {{14{CH_SPACE}}, "D", CH_SPACE});
    add_step(KEY_D, 1, 1'b0, 8'h00, '0);
    add_step(KEY_B, 1, 1'b0, 8'h00, '0);                     // back to numbers
    add_step(KEY_7, 1, 1'b0, "7", LINE_BITS'("7"));
  endfunction

  // scanner back in its debounce state means the key was seen as released
  task automatic wait_idle();
    @(negedge clk);
    while (dut.u_scanner.state != SC_IDLE)
      @(negedge clk);
  endtask

  task automatic press_key(input logic [7:0] code, input int hold);
    @(posedge clk);
    key <= code;
    repeat (hold) @(posedge clk);
    key <= '0;
    wait_idle();
    repeat (SETTLE) @(negedge clk);
  endtask

  initial begin : main
    int i;
    int r;
    void'($urandom(41));
    nrst = 1'b0;
    key  = '0;
    build_table();
    for (i = 0; i < step_key.size(); i++)
      limit_cycles += step_reps[i] * (step_hold[i] + (DEBOUNCE_CNT + 4) * ROUND);
    limit_cycles += 10 * ROUND;  // reset and margin
    repeat (3) @(posedge clk);
    nrst <= 1'b1;
    @(negedge clk);
    check_value("cols", LINE_BITS'(cols), LINE_BITS'(4'b0001));
    check_value("text", text, '0);
    for (i = 0; i < step_key.size(); i++) begin
      for (r = 0; r < step_reps[i]; r++)
        press_key(step_key[i], step_hold[i]);
      check_value("text[7:0]", LINE_BITS'(text[7:0]), LINE_BITS'(step_low[i]));
      check_value("text", text, step_text[i]);
    end
    $display("TEST PASS");
    $finish;
  end

  initial begin : watchdog
    wait (limit_cycles != 0);
    #(limit_cycles * CLK_PERIOD);
    $display("timeout: the key sequence did not finish within %0d cycles", limit_cycles);
    $display("TEST FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

/* tests/keypad_model.sv */
`timescale 1ns/1ns

module keypad_model import keypad_pkg::*; (
  input  logic [3:0] cols,
  input  key_code_t  key,   // raw 0 means nothing pressed
  output logic [3:0] rows
);

  logic col_driven;

  // a closed switch shorts its row to its column while that column is driven
  assign col_driven = (key.pos.col & cols) != 4'b0000;
  assign rows       = col_driven ? key.pos.row : 4'b0000;

endmodule

/* src/keypad_text_top.sv */
`timescale 1ns/1ns

module keypad_text_top import keypad_pkg::*; (
  input  logic                 clk,
  input  logic                 nrst,
  input  logic [3:0]           rows,
  output logic [3:0]           cols,
  output logic [LINE_BITS-1:0] text
);

  logic      key_req;   // scanner event, four-phase
  logic      key_ack;
  key_code_t key_code;

  key_edit_if edit_bus ();

  keypad_scanner u_scanner (
    .clk      (clk),
    .nrst     (nrst),
    .rows     (rows),
    .cols     (cols),
    .key_req  (key_req),
    .key_ack  (key_ack),
    .key_code (key_code)
  );

  // multi-tap and mode state
  tap_tracker u_tracker (
    .clk      (clk),
    .nrst     (nrst),
    .key_req  (key_req),
    .key_ack  (key_ack),
    .key_code (key_code),
    .edit     (edit_bus)
  );

  text_decoder u_decoder (
    .clk  (clk),
    .nrst (nrst),
    .edit (edit_bus),
    .text (text)
  );

endmodule

/* src/text_decoder.sv */
`timescale 1ns/1ns

module text_decoder import keypad_pkg::*; (
  input  logic                 clk,
  input  logic                 nrst,
  key_edit_if.sink             edit,
  output logic [LINE_BITS-1:0] text
);

  logic                 apply;
  logic [1:0]           tap;
  logic                 up;
  logic [7:0]           cur_char;
  logic [7:0]           num_char;
  logic [7:0]           txt_char;
  logic [7:0]           new_char;
  logic [LINE_BITS-1:0] next_text;

  function automatic logic [7:0] sym_char(input logic [1:0] sel, input logic [7:0] s0,
                                          input logic [7:0] s1, input logic [7:0] s2,
                                          input logic [7:0] s3);
    case (sel)
      2'd0:    return s0;
      2'd1:    return s1;
      2'd2:    return s2;
      default: return s3;
    endcase
  endfunction

  // base is the letter offset of the key, wide marks the four-letter keys
  function automatic logic [7:0] letter_char(input logic [4:0] base, input logic wide,
                                             input logic upc, input logic [1:0] sel,
                                             input logic [7:0] cur);
    logic [7:0] lower;
    lower = CH_LOWER_A + 8'(base) + 8'(sel);
    if (sel == 2'd3 && !wide)
      return cur;  // no fourth letter, keep it
    return upc ? lower - CH_CASE_GAP : lower;
  endfunction

  assign apply    = edit.req && !edit.ack;  // first cycle of a request
  assign tap      = edit.tap_count;
  assign up       = edit.upper;
  assign cur_char = text[CHAR_BITS-1:0];

  always_comb begin
    case (edit.code.raw)
      KEY_1:    num_char = CH_DIGIT0 + 8'd1;
      KEY_2:    num_char = CH_DIGIT0 + 8'd2;
      KEY_3:    num_char = CH_DIGIT0 + 8'd3;
      KEY_4:    num_char = CH_DIGIT0 + 8'd4;
      KEY_5:    num_char = CH_DIGIT0 + 8'd5;
      KEY_6:    num_char = CH_DIGIT0 + 8'd6;
      KEY_7:    num_char = CH_DIGIT0 + 8'd7;
      KEY_8:    num_char = CH_DIGIT0 + 8'd8;
      KEY_9:    num_char = CH_DIGIT0 + 8'd9;
      KEY_0:    num_char = CH_DIGIT0;
      KEY_STAR: num_char = CH_STAR;
      KEY_HASH: num_char = CH_HASH;
      default:  num_char = cur_char;
    endcase
  end

  always_comb begin
    case (edit.code.raw)
      KEY_1:    txt_char = sym_char(tap, CH_AT, CH_UNDERSCORE, CH_AMP, CH_COLON);
      KEY_STAR: txt_char = sym_char(tap, CH_PLUS, CH_MINUS, CH_SLASH, CH_EQUALS);
      KEY_0:    txt_char = sym_char(tap, CH_COMMA, CH_PERIOD, CH_QUESTION, CH_BANG);
      KEY_HASH: txt_char = CH_NULL;  // case change leaves a null cell
      KEY_2:    txt_char = letter_char(5'd0, 1'b0, up, tap, cur_char);   // abc
      KEY_3:    txt_char = letter_char(5'd3, 1'b0, up, tap, cur_char);   // def
      KEY_4:    txt_char = letter_char(5'd6, 1'b0, up, tap, cur_char);   // ghi
      KEY_5:    txt_char = letter_char(5'd9, 1'b0, up, tap, cur_char);   // jkl
      KEY_6:    txt_char = letter_char(5'd12, 1'b0, up, tap, cur_char);  // mno
      KEY_7:    txt_char = letter_char(5'd15, 1'b1, up, tap, cur_char);  // pqrs
      KEY_8:    txt_char = letter_char(5'd19, 1'b0, up, tap, cur_char);  // tuv
      KEY_9:    txt_char = letter_char(5'd22, 1'b1, up, tap, cur_char);  // wxyz
      default:  txt_char = cur_char;
    endcase
  end

  assign new_char = edit.letter_mode ? txt_char : num_char;

  always_comb begin
    next_text = text;
    case (edit.code.raw)
      KEY_A: next_text = {CH_SPACE, text[LINE_BITS-1:CHAR_BITS]};  // space at the top
      KEY_C: next_text = {text[LINE_BITS-CHAR_BITS-1:0], CH_SPACE};  // confirm cell
      KEY_D: begin
        if (!edit.letter_mode || edit.code_prev.raw == KEY_C)
          next_text = '0;
      end
      KEY_B: next_text = text;  // mode toggle only
      default: next_text[CHAR_BITS-1:0] = new_char;
    endcase
  end

  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      text     <= '0;
      edit.ack <= 1'b0;
    end else begin
      if (apply) begin
        text     <= next_text;
        edit.ack <= 1'b1;
      end else if (!edit.req) begin
        edit.ack <= 1'b0;
      end
    end
  end

  // the line moves only on the edge right after a fresh request
  a_text_timing: assert property (@(posedge clk) disable iff (!nrst)
    $changed(text) |-> $past(edit.req) && !$past(edit.req, 2));

endmodule

/* src/tap_tracker.sv */
`timescale 1ns/1ns

module tap_tracker import keypad_pkg::*; (
  input  logic       clk,
  input  logic       nrst,
  input  logic       key_req,
  output logic       key_ack,
  input  key_code_t  key_code,
  key_edit_if.source edit
);

  logic       accept;
  logic       same_key;
  logic [1:0] next_tap;
  logic       next_mode;
  logic       next_upper;

  // take a new key only when both handshakes are back at rest
  assign accept = key_req && !key_ack && !edit.req && !edit.ack;

  always_comb begin
    same_key   = (key_code.raw == edit.code.raw) && (key_code.raw != KEY_C);
    next_tap   = same_key ? edit.tap_count + 2'd1 : 2'd0;  // wraps after 3
    next_mode  = edit.letter_mode;
    next_upper = edit.upper;
    if (key_code.raw == KEY_B)
      next_mode = !edit.letter_mode;
    if (key_code.raw == KEY_HASH && edit.letter_mode)
      next_upper = !edit.upper;  // # is the case key in letter mode
  end

  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      key_ack          <= 1'b0;
      edit.req         <= 1'b0;
      edit.code        <= '0;  // matches no key
      edit.code_prev   <= '0;
      edit.tap_count   <= 2'd0;
      edit.letter_mode <= 1'b0;
      edit.upper       <= 1'b0;
    end else if (accept) begin
      key_ack          <= 1'b1;
      edit.req         <= 1'b1;  // same edge as key_ack
      edit.code        <= key_code;
      edit.code_prev   <= edit.code;
      edit.tap_count   <= next_tap;
      edit.letter_mode <= next_mode;
      edit.upper       <= next_upper;
    end else begin
      if (key_ack && !key_req)
        key_ack <= 1'b0;
      if (edit.req && edit.ack)
        edit.req <= 1'b0;
    end
  end

  // decoder must have closed the last edit before a new one opens
  a_req_after_ack: assert property (@(posedge clk) disable iff (!nrst)
    $rose(edit.req) |-> !edit.ack);

endmodule

/* src/keypad_scanner.sv */
`timescale 1ns/1ns

module keypad_scanner import keypad_pkg::*; (
  input  logic       clk,
  input  logic       nrst,
  input  logic [3:0] rows,
  output logic [3:0] cols,
  output logic       key_req,
  input  logic       key_ack,
  output key_code_t  key_code
);

  logic [3:0]       rows_meta;
  logic [3:0]       rows_sync;
  logic [DIV_W-1:0] div_cnt;
  logic             slot_end;
  logic             round_end;
  logic             slot_hit;
  logic             acc_any;    // a key was seen earlier in this round
  key_code_t        acc_code;
  logic             seen;
  key_code_t        seen_code;
  key_code_t        cand;       // debounce candidate
  logic [DEB_W-1:0] deb_cnt;
  logic             fire;
  logic [1:0]       state;

  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      rows_meta <= '0;
      rows_sync <= '0;
    end else begin
      rows_meta <= rows;  // rows come from the keypad unsynchronized
      rows_sync <= rows_meta;
    end
  end

  // sync delay is 2 clocks, so the slot end still sees its own column
  assign slot_end  = (div_cnt == DIV_W'(SCAN_DIV - 1));
  assign round_end = slot_end && cols[3];
  assign slot_hit  = slot_end && $onehot(rows_sync);  // single row only

  always_comb begin
    seen      = acc_any || slot_hit;
    seen_code = acc_code;
    if (!acc_any) begin
      seen_code.pos.row = rows_sync;
      seen_code.pos.col = cols;
    end
  end

  assign fire = (state == SC_IDLE) && round_end && seen && (seen_code == cand) &&
                (deb_cnt == DEB_W'(DEBOUNCE_CNT - 1));

  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      div_cnt <= '0;
      cols    <= 4'b0001;
    end else if (slot_end) begin
      div_cnt <= '0;
      cols    <= {cols[2:0], cols[3]};  // next column
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      acc_any  <= 1'b0;
      acc_code <= '0;
    end else if (round_end) begin
      acc_any <= 1'b0;
    end else if (slot_hit && !acc_any) begin
      acc_any  <= 1'b1;  // first key of the round wins
      acc_code <= seen_code;
    end
  end

  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      state   <= SC_IDLE;
      key_req <= 1'b0;
      cand    <= '0;
      deb_cnt <= '0;
    end else begin
      case (state)
        SC_IDLE: begin
          if (fire) begin
            key_req <= 1'b1;
            cand    <= '0;
            deb_cnt <= '0;
            state   <= SC_WAIT_ACK;
          end else if (round_end) begin
            if (seen && seen_code == cand) begin
              deb_cnt <= deb_cnt + 1'b1;  // same place again
            end else begin
              cand    <= seen ? seen_code : '0;
              deb_cnt <= seen ? DEB_W'(1) : '0;
            end
          end
        end
        SC_WAIT_ACK: begin
          if (key_ack) begin
            key_req <= 1'b0;
            state   <= SC_WAIT_DROP;
          end
        end
        SC_WAIT_DROP: begin
          if (!key_ack)
            state <= SC_RELEASE;
        end
        default: begin
          if (round_end && !seen)
            state <= SC_IDLE;  // one empty round means released
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (fire)
      key_code <= cand;
  end

  a_code_onehot: assert property (@(posedge clk) disable iff (!nrst)
    key_req |-> $onehot(key_code.pos.row) && $onehot(key_code.pos.col));

endmodule

/* src/key_edit_if.sv */
`timescale 1ns/1ns

interface key_edit_if import keypad_pkg::*; ();

  logic       req;          // four-phase request
  logic       ack;          // four-phase acknowledge
  key_code_t  code;         // key of this edit
  key_code_t  code_prev;    // key of the edit before
  logic [1:0] tap_count;    // repeats of the same key, mod 4
  logic       letter_mode;  // 0 = number mode
  logic       upper;        // letter case

  modport source (
    output req,
    output code,
    output code_prev,
    output tap_count,
    output letter_mode,
    output upper,
    input  ack
  );

  modport sink (
    input  req,
    input  code,
    input  code_prev,
    input  tap_count,
    input  letter_mode,
    input  upper,
    output ack
  );

endinterface

/* src/keypad_pkg.sv */
package keypad_pkg;

  // line buffer geometry
  localparam int CHAR_BITS  = 8;
  localparam int LINE_CHARS = 16;
  localparam int LINE_BITS  = LINE_CHARS * CHAR_BITS;  // 128 bits, low cell is [7:0]

  // scanner timing
  localparam int SCAN_DIV     = 4;  // clocks per column slot
  localparam int DEBOUNCE_CNT = 3;  // matching scan rounds before an event
  localparam int DIV_W        = $clog2(SCAN_DIV);
  localparam int DEB_W        = $clog2(DEBOUNCE_CNT + 1);

  // scanner FSM encoding
  localparam logic [1:0] SC_IDLE      = 2'd0;  // debouncing
  localparam logic [1:0] SC_WAIT_ACK  = 2'd1;  // key_req high
  localparam logic [1:0] SC_WAIT_DROP = 2'd2;  // key_req low, ack still high
  localparam logic [1:0] SC_RELEASE   = 2'd3;  // waiting for an empty round

  // one key position, row one-hot in the high nibble, column in the low
  typedef union packed {
    logic [7:0] raw;
    struct packed {
      logic [3:0] row;
      logic [3:0] col;
    } pos;
  } key_code_t;

  // key codes as seen on the keypad matrix
  localparam logic [7:0] KEY_1    = 8'b0001_0001;
  localparam logic [7:0] KEY_2    = 8'b0001_0010;
  localparam logic [7:0] KEY_3    = 8'b0001_0100;
  localparam logic [7:0] KEY_A    = 8'b0001_1000;
  localparam logic [7:0] KEY_4    = 8'b0010_0001;
  localparam logic [7:0] KEY_5    = 8'b0010_0010;
  localparam logic [7:0] KEY_6    = 8'b0010_0100;
  localparam logic [7:0] KEY_HASH = 8'b0010_1000;
  localparam logic [7:0] KEY_7    = 8'b0100_0001;
  localparam logic [7:0] KEY_8    = 8'b0100_0010;
  localparam logic [7:0] KEY_9    = 8'b0100_0100;
  localparam logic [7:0] KEY_C    = 8'b0100_1000;
  localparam logic [7:0] KEY_STAR = 8'b1000_0001;
  localparam logic [7:0] KEY_0    = 8'b1000_0010;
  localparam logic [7:0] KEY_B    = 8'b1000_0100;
  localparam logic [7:0] KEY_D    = 8'b1000_1000;

  // ASCII bases
  localparam logic [7:0] CH_NULL     = 8'h00;
  localparam logic [7:0] CH_SPACE    = 8'h20;
  localparam logic [7:0] CH_DIGIT0   = 8'h30;
  localparam logic [7:0] CH_LOWER_A  = 8'h61;
  localparam logic [7:0] CH_CASE_GAP = 8'h20;  // lower minus upper

  // number mode symbols
  localparam logic [7:0] CH_STAR = 8'h2a;
  localparam logic [7:0] CH_HASH = 8'h23;

  // key 1 in letter mode
  localparam logic [7:0] CH_AT         = 8'h40;
  localparam logic [7:0] CH_UNDERSCORE = 8'h5f;
  localparam logic [7:0] CH_AMP        = 8'h26;
  localparam logic [7:0] CH_COLON      = 8'h3a;

  // key * in letter mode
  localparam logic [7:0] CH_PLUS   = 8'h2b;
  localparam logic [7:0] CH_MINUS  = 8'h2d;
  localparam logic [7:0] CH_SLASH  = 8'h2f;
  localparam logic [7:0] CH_EQUALS = 8'h3d;

  // key 0 in letter mode
  localparam logic [7:0] CH_COMMA    = 8'h2c;
  localparam logic [7:0] CH_PERIOD   = 8'h2e;
  localparam logic [7:0] CH_QUESTION = 8'h3f;
  localparam logic [7:0] CH_BANG     = 8'h21;

endpackage
